// ==== Makefile ====
TOP := tb_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f sim.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log || (echo "simulation did not finish"; exit 1)

lint:
	verilator --lint-only -Ihw hw/stream_pkg.sv hw/sync_fifo.sv hw/axil_push_port.sv \
		hw/fifo_accumulator.sv hw/stream_acc_top.sv --top-module stream_acc_top
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== hw/axil_push_port.sv ====
`include "stream_cfg.svh"

module axil_push_port (
  input  logic                  clk,
  input  logic                  rst_n,
  input  stream_pkg::axil_aw_w_t wr_req,
  input  logic                  bready,
  input  logic                  overflow,
  output logic                  awready,
  output logic                  wready,
  output stream_pkg::axil_b_t   wr_rsp,
  output stream_pkg::word_t     push_data,
  output logic                  shift_in,
  output stream_pkg::acc_ctrl_t ctrl
);

  logic                  accept_r;
  logic                  wr_fire;
  logic                  sel_data;
  logic                  sel_ctrl;
  stream_pkg::axil_b_t   b_r;
  stream_pkg::acc_ctrl_t ctrl_r;

  assign awready = accept_r;
  assign wready  = accept_r;
  assign wr_fire = accept_r && wr_req.awvalid && wr_req.wvalid;

  assign sel_data = (wr_req.awaddr == `REG_DATA);
  assign sel_ctrl = (wr_req.awaddr == `REG_CTRL);

  // the push goes out in the handshake cycle, the FIFO flags it right away
  assign shift_in  = wr_fire && sel_data;
  assign push_data = wr_req.wdata;

  assign wr_rsp = b_r;
  assign ctrl   = ctrl_r;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      accept_r <= 1'b0;
      b_r      <= '0;
      ctrl_r   <= '0;
    end
    else
    begin
      // one ready pulse per address/data pair, never while a response waits
      accept_r <= wr_req.awvalid && wr_req.wvalid && !accept_r && !b_r.bvalid;

      ctrl_r.clear <= 1'b0;
      ctrl_r.drop  <= 1'b0;

      if (b_r.bvalid && bready)
      begin
        b_r.bvalid <= 1'b0;
      end

      if (wr_fire)
      begin
        b_r.bvalid <= 1'b1;
        if (sel_data)
        begin
          // a full FIFO loses the word but the bus keeps moving
          b_r.bresp   <= overflow ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
          ctrl_r.drop <= overflow;
        end
        else if (sel_ctrl)
        begin
          b_r.bresp    <= `AXI_RESP_OKAY;
          ctrl_r.run   <= wr_req.wdata[0];
          ctrl_r.clear <= wr_req.wdata[1];
        end
        else
        begin
          b_r.bresp <= `AXI_RESP_SLVERR;  // unmapped, no side effect
        end
      end
    end
  end

endmodule

// ==== hw/fifo_accumulator.sv ====
`include "stream_cfg.svh"

module fifo_accumulator (
  input  logic                  clk,
  input  logic                  rst_n,
  input  stream_pkg::acc_ctrl_t ctrl,
  input  stream_pkg::word_t     fifo_dout,
  input  logic                  fifo_valid,
  input  logic                  fifo_empty,
  input  logic                  fifo_full,
  input  stream_pkg::axil_ar_t  rd_req,
  input  logic                  rready,
  output logic                  shift_out,
  output logic                  arready,
  output stream_pkg::axil_r_t   rd_rsp
);

  stream_pkg::acc_state_t state_r;
  stream_pkg::acc_state_t state_nxt;
  stream_pkg::word_t      sum_r;
  stream_pkg::word_t      count_r;
  stream_pkg::word_t      rd_data;
  stream_pkg::word_t      rdata_r;
  stream_pkg::resp_t      rd_resp;
  stream_pkg::resp_t      rresp_r;
  logic                   rvalid_r;
  logic                   sticky_r;
  logic                   idle;
  logic                   rd_fire;

  // ACC_ADD is the cycle right after a word landed and may pop again at once
  assign shift_out = ctrl.run && !fifo_empty &&
                     (state_r == stream_pkg::ACC_IDLE || state_r == stream_pkg::ACC_ADD);
  assign idle = fifo_empty && (state_r != stream_pkg::ACC_WAIT);

  always_comb
  begin
    state_nxt = state_r;
    case (state_r)
      stream_pkg::ACC_IDLE,
      stream_pkg::ACC_ADD:
      begin
        state_nxt = shift_out ? stream_pkg::ACC_WAIT : stream_pkg::ACC_IDLE;
      end
      stream_pkg::ACC_WAIT:
      begin
        if (fifo_valid)
        begin
          state_nxt = stream_pkg::ACC_ADD;
        end
      end
      default:
      begin
        state_nxt = stream_pkg::ACC_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_r  <= stream_pkg::ACC_IDLE;
      sum_r    <= '0;
      count_r  <= '0;
      sticky_r <= 1'b0;
    end
    else
    begin
      state_r <= state_nxt;
      if (ctrl.clear)
      begin
        sum_r    <= '0;
        count_r  <= '0;
        sticky_r <= 1'b0;
      end
      else if (state_r == stream_pkg::ACC_WAIT && fifo_valid)
      begin
        sum_r   <= sum_r + fifo_dout;  // wraps modulo 2^32
        count_r <= count_r + 1'b1;
      end
      if (ctrl.drop)
      begin
        sticky_r <= 1'b1;
      end
    end
  end

  assign arready = !rvalid_r;
  assign rd_fire = rd_req.arvalid && arready;

  always_comb
  begin
    rd_data = '0;
    rd_resp = `AXI_RESP_OKAY;
    case (rd_req.araddr)
      `REG_CTRL:   rd_data = stream_pkg::word_t'(ctrl.run);  // clear always reads 0
      `REG_SUM:    rd_data = sum_r;
      `REG_COUNT:  rd_data = count_r;
      `REG_STATUS: rd_data = stream_pkg::word_t'({sticky_r, fifo_full, idle});
      default:     rd_resp = `AXI_RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      rvalid_r <= 1'b0;
    end
    else if (rd_fire)
    begin
      rvalid_r <= 1'b1;
    end
    else if (rready)
    begin
      rvalid_r <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rd_fire)
    begin
      rdata_r <= rd_data;  // snapshot taken at address acceptance
      rresp_r <= rd_resp;
    end
  end

  assign rd_rsp.rdata  = rdata_r;
  assign rd_rsp.rresp  = rresp_r;
  assign rd_rsp.rvalid = rvalid_r;

  pop_answered: assert property (@(posedge clk) disable iff (!rst_n)
    shift_out |=> fifo_valid)
    else $error("FIFO did not answer a pop");

  valid_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
    fifo_valid |-> state_r == stream_pkg::ACC_WAIT)
    else $error("FIFO valid outside ACC_WAIT");

endmodule

// ==== hw/stream_acc_top.sv ====
`include "stream_cfg.svh"

module stream_acc_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  stream_pkg::axil_aw_w_t wr_req,
  input  logic                   bready,
  input  stream_pkg::axil_ar_t   rd_req,
  input  logic                   rready,
  output logic                   awready,
  output logic                   wready,
  output stream_pkg::axil_b_t    wr_rsp,
  output logic                   arready,
  output stream_pkg::axil_r_t    rd_rsp
);

  stream_pkg::word_t     push_data;
  stream_pkg::word_t     fifo_dout;
  stream_pkg::acc_ctrl_t ctrl;
  logic                  shift_in;
  logic                  shift_out;
  logic                  fifo_valid;
  logic                  fifo_full;
  logic                  fifo_empty;
  logic                  fifo_overflow;

  axil_push_port u_push (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_req    (wr_req),
    .bready    (bready),
    .overflow  (fifo_overflow),
    .awready   (awready),
    .wready    (wready),
    .wr_rsp    (wr_rsp),
    .push_data (push_data),
    .shift_in  (shift_in),
    .ctrl      (ctrl)
  );

  sync_fifo #(
    .DATA_WIDTH   (`STREAM_DATA_W),
    .DEPTH        (`STREAM_FIFO_DEPTH),
    .READ_LATENCY (`STREAM_FIFO_LAT)
  ) u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .din       (push_data),
    .shift_in  (shift_in),
    .shift_out (shift_out),
    .dout      (fifo_dout),
    .valid     (fifo_valid),
    .full      (fifo_full),
    .empty     (fifo_empty),
    .overflow  (fifo_overflow),
    .underflow ()
  );

  fifo_accumulator u_acc (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .fifo_dout  (fifo_dout),
    .fifo_valid (fifo_valid),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full),
    .rd_req     (rd_req),
    .rready     (rready),
    .shift_out  (shift_out),
    .arready    (arready),
    .rd_rsp     (rd_rsp)
  );

endmodule

// ==== hw/stream_cfg.svh ====
`ifndef STREAM_CFG_SVH
`define STREAM_CFG_SVH

`define STREAM_DATA_W      32
`define STREAM_ADDR_W      8
`define STREAM_FIFO_DEPTH  8      // one slot stays free, so 7 words fit
`define STREAM_FIFO_LAT    1

`define REG_DATA           8'h00
`define REG_CTRL           8'h04
`define REG_SUM            8'h08
`define REG_COUNT          8'h0C
`define REG_STATUS         8'h10

`define AXI_RESP_OKAY      2'b00
`define AXI_RESP_SLVERR    2'b10

`endif

// ==== hw/stream_pkg.sv ====
`include "stream_cfg.svh"

package stream_pkg;

  typedef logic [`STREAM_DATA_W-1:0] word_t;
  typedef logic [`STREAM_ADDR_W-1:0] addr_t;
  typedef logic [1:0]                resp_t;

  // host side of the write address and write data channels
  typedef struct packed {
    addr_t awaddr;
    logic  awvalid;
    word_t wdata;
    logic  wvalid;
  } axil_aw_w_t;

  typedef struct packed {
    resp_t bresp;
    logic  bvalid;
  } axil_b_t;

  typedef struct packed {
    addr_t araddr;
    logic  arvalid;
  } axil_ar_t;

  typedef struct packed {
    word_t rdata;
    resp_t rresp;
    logic  rvalid;
  } axil_r_t;

  typedef struct packed {
    logic run;    // level from the control register
    logic clear;  // single-cycle pulse
    logic drop;   // single-cycle pulse when a push hit a full FIFO
  } acc_ctrl_t;

  typedef enum logic [1:0] {
    ACC_IDLE = 2'd0,
    ACC_WAIT = 2'd1,
    ACC_ADD  = 2'd2
  } acc_state_t;

endpackage

// ==== hw/sync_fifo.sv ====
module sync_fifo #(
  parameter int DATA_WIDTH   = 32,
  parameter int DEPTH        = 16,
  parameter int READ_LATENCY = 0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [DATA_WIDTH-1:0] din,
  input  logic                  shift_in,
  input  logic                  shift_out,
  output logic [DATA_WIDTH-1:0] dout,
  output logic                  valid,
  output logic                  full,
  output logic                  empty,
  output logic                  overflow,
  output logic                  underflow
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr_r;
  logic [PTR_W-1:0]      rd_ptr_r;
  logic [PTR_W-1:0]      wr_ptr_inc;
  logic [PTR_W-1:0]      rd_ptr_inc;
  logic                  do_push;
  logic                  do_pop;

  // pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (int'(ptr) == DEPTH - 1)
    begin
      nxt = '0;
    end
    else
    begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign wr_ptr_inc = ptr_next(wr_ptr_r);
  assign rd_ptr_inc = ptr_next(rd_ptr_r);

  assign empty     = (wr_ptr_r == rd_ptr_r);
  assign full      = (wr_ptr_inc == rd_ptr_r);  // DEPTH-1 words held
  assign overflow  = shift_in && full;
  assign underflow = shift_out && empty;
  assign do_push   = shift_in && !full;
  assign do_pop    = shift_out && !empty;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr_r <= wr_ptr_inc;
      end
      if (do_pop)
      begin
        rd_ptr_r <= rd_ptr_inc;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr_r] <= din;
    end
  end

  generate
    if (READ_LATENCY == 0)
    begin : g_lat0
      assign dout  = (shift_in && empty) ? din : mem[rd_ptr_r];  // bypass when empty
      assign valid = shift_out;
    end
    else
    begin : g_lat1
      logic [DATA_WIDTH-1:0] dout_r;
      logic                  valid_r;

      always_ff @(posedge clk)
      begin
        if (!rst_n)
        begin
          valid_r <= 1'b0;
        end
        else
        begin
          valid_r <= shift_out;
        end
      end

      always_ff @(posedge clk)
      begin
        if (do_pop)
        begin
          dout_r <= mem[rd_ptr_r];
        end
      end

      assign dout  = dout_r;
      assign valid = valid_r;
    end
  endgenerate

  ptr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    (int'(wr_ptr_r) < DEPTH) && (int'(rd_ptr_r) < DEPTH))
    else $error("fifo pointer out of range");

endmodule

// ==== sim.f ====
+incdir+hw
hw/stream_pkg.sv
hw/sync_fifo.sv
hw/axil_push_port.sv
hw/fifo_accumulator.sv
hw/stream_acc_top.sv
verif/acc_checker.sv
verif/tb_top.sv

// ==== verif/acc_checker.sv ====
`include "stream_cfg.svh"

module acc_checker (
  input  logic                clk,
  input  logic                rst_n,
  input  stream_pkg::axil_b_t wr_rsp,
  input  logic                bready,
  input  stream_pkg::axil_r_t rd_rsp,
  input  logic                rready,
  output int                  checked,
  output int                  errors,
  output int                  pending
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_OPS = 64;

  logic [7:0]        ops   [MAX_OPS];
  stream_pkg::word_t datas [MAX_OPS];
  stream_pkg::resp_t resps [MAX_OPS];
  logic [8*20-1:0]   names [MAX_OPS];
  int                n_ops;
  int                idx;

  assign pending = n_ops - idx;

  initial
  begin
    int                fd;
    int                code;
    logic [7:0]        op;
    logic [8*120-1:0]  rest;
    stream_pkg::addr_t a;
    stream_pkg::word_t d;
    stream_pkg::resp_t r;
    logic [8*20-1:0]   nm;
    n_ops = 0;
    fd = $fopen("verif/acc_golden.txt", "r");
    if (fd == 0)
    begin
      $display("checker cannot open verif/acc_golden.txt");
    end
    else
    begin
      while (n_ops < MAX_OPS)
      begin
        code = $fscanf(fd, "%s", op);
        if (code != 1)
        begin
          break;
        end
        if (op == "#")
        begin
          code = $fgets(rest, fd);
        end
        else
        begin
          code = $fscanf(fd, "%h %h %h %s", a, d, r, nm);
          ops[n_ops]   = op;
          datas[n_ops] = d;
          resps[n_ops] = r;
          names[n_ops] = nm;
          n_ops++;
        end
      end
      $fclose(fd);
    end
  end

  task automatic compare(input string what, input stream_pkg::word_t exp,
                         input stream_pkg::word_t act);
    if (exp !== act)
    begin
      $display("CHECK FAILED %0s %0s: expected 0x%0h, actual 0x%0h", names[idx], what, exp, act);
      errors++;
    end
  endtask

  task automatic check_b();
    if (idx >= n_ops || ops[idx] != "W")
    begin
      $display("write response arrived with no matching write line");
      errors++;
    end
    else
    begin
      compare("bresp", stream_pkg::word_t'(resps[idx]), stream_pkg::word_t'(wr_rsp.bresp));
      checked++;
      idx++;
    end
  endtask

  task automatic check_r();
    if (idx >= n_ops)
    begin
      $display("read response arrived after the last golden line");
      errors++;
    end
    else if (ops[idx] == "P")
    begin
      compare("poll rresp", stream_pkg::word_t'(`AXI_RESP_OKAY),
              stream_pkg::word_t'(rd_rsp.rresp));
      if (rd_rsp.rdata[0])
      begin
        idx++;  // the poll ends on the first idle status
      end
    end
    else if (ops[idx] == "R")
    begin
      compare("rresp", stream_pkg::word_t'(resps[idx]), stream_pkg::word_t'(rd_rsp.rresp));
      compare("rdata", datas[idx], rd_rsp.rdata);
      checked++;
      idx++;
    end
    else
    begin
      $display("read response arrived where a write response was expected");
      errors++;
    end
  endtask

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (wr_rsp.bvalid && bready)
      begin
        check_b();
      end
      if (rd_rsp.rvalid && rready)
      begin
        check_r();
      end
    end
  end

endmodule

// ==== verif/acc_golden.txt ====
# op addr data resp name   (hex fields; W: data is written and resp expected)
# R: resp and data expected; P: poll STATUS until idle, other fields unused
R 04 00000000 0 rst_ctrl
R 08 00000000 0 rst_sum
R 0C 00000000 0 rst_count
R 10 00000001 0 rst_status
W 04 00000001 0 acc_run
W 00 12345678 0 acc_w0
W 00 00000100 0 acc_w1
W 00 FFFFFF00 0 acc_w2
W 00 00000300 0 acc_w3
P 10 00000000 0 acc_drain
R 08 12345978 0 acc_sum
R 0C 00000004 0 acc_count
R 10 00000001 0 acc_status
W 04 00000002 0 ovf_clear_stop
R 04 00000000 0 ovf_ctrl
W 00 00000011 0 ovf_w1
W 00 00000022 0 ovf_w2
W 00 00000033 0 ovf_w3
W 00 00000044 0 ovf_w4
W 00 00000055 0 ovf_w5
W 00 00000066 0 ovf_w6
W 00 00000077 0 ovf_w7
R 10 00000002 0 ovf_full
W 00 00000088 2 ovf_w8
R 10 00000006 0 ovf_sticky
W 04 00000001 0 ovf_run
P 10 00000000 0 ovf_drain
R 08 000001DC 0 ovf_sum
R 0C 00000007 0 ovf_count
R 10 00000005 0 ovf_status
W 04 00000003 0 clr_run_clear
R 08 00000000 0 clr_sum
R 0C 00000000 0 clr_count
R 10 00000001 0 clr_status
R 04 00000001 0 clr_ctrl
W 00 00000042 0 dec_seed
P 10 00000000 0 dec_drain
W 14 DEADBEEF 2 dec_w_unmapped
W 08 00000001 2 dec_w_sum_ro
R 14 00000000 2 dec_r_unmapped
R 00 00000000 2 dec_r_data_wo
R 08 00000042 0 dec_sum
R 0C 00000001 0 dec_count

// ==== verif/tb_top.sv ====
`include "stream_cfg.svh"

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_OPS    = 64;
  localparam int HS_LIMIT   = 64;   // cycles allowed for any single handshake
  localparam int POLL_LIMIT = 100;  // status reads allowed per poll

  logic                   clk;
  logic                   rst_n;
  stream_pkg::axil_aw_w_t wr_req;
  logic                   bready;
  stream_pkg::axil_ar_t   rd_req;
  logic                   rready;
  logic                   awready;
  logic                   wready;
  stream_pkg::axil_b_t    wr_rsp;
  logic                   arready;
  stream_pkg::axil_r_t    rd_rsp;

  logic [7:0]        ops   [MAX_OPS];
  stream_pkg::addr_t addrs [MAX_OPS];
  stream_pkg::word_t datas [MAX_OPS];
  int                n_ops;
  int                tb_errors;
  int                checked;
  int                check_errors;
  int                pending;

  stream_acc_top dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_req  (wr_req),
    .bready  (bready),
    .rd_req  (rd_req),
    .rready  (rready),
    .awready (awready),
    .wready  (wready),
    .wr_rsp  (wr_rsp),
    .arready (arready),
    .rd_rsp  (rd_rsp)
  );

  acc_checker u_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_rsp  (wr_rsp),
    .bready  (bready),
    .rd_rsp  (rd_rsp),
    .rready  (rready),
    .checked (checked),
    .errors  (check_errors),
    .pending (pending)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic load_ops();
    int                fd;
    int                code;
    logic [7:0]        op;
    logic [8*120-1:0]  rest;
    stream_pkg::addr_t a;
    stream_pkg::word_t d;
    stream_pkg::resp_t r;
    logic [8*20-1:0]   nm;
    n_ops = 0;
    fd = $fopen("verif/acc_golden.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open verif/acc_golden.txt");
      tb_errors++;
      return;
    end
    while (n_ops < MAX_OPS)
    begin
      code = $fscanf(fd, "%s", op);
      if (code != 1)
      begin
        break;
      end
      if (op == "#")
      begin
        code = $fgets(rest, fd);  // comment line
      end
      else
      begin
        code = $fscanf(fd, "%h %h %h %s", a, d, r, nm);
        ops[n_ops]   = op;
        addrs[n_ops] = a;
        datas[n_ops] = d;
        n_ops++;
      end
    end
    $fclose(fd);
  endtask

  // every bus task starts and ends on a falling edge
  task automatic axil_write(input stream_pkg::addr_t addr, input stream_pkg::word_t data);
    int   n;
    logic ok;
    ok = 1'b0;
    wr_req.awaddr  = addr;
    wr_req.wdata   = data;
    wr_req.awvalid = 1'b1;
    wr_req.wvalid  = 1'b1;
    n = 0;
    while (!ok && n < HS_LIMIT)
    begin
      @(posedge clk);
      ok = awready && wready;
      @(negedge clk);
      n++;
    end
    wr_req.awvalid = 1'b0;
    wr_req.wvalid  = 1'b0;
    if (!ok)
    begin
      $display("write handshake timed out at address 0x%h", addr);
      tb_errors++;
      return;
    end
    ok = 1'b0;
    n = 0;
    while (!ok && n < HS_LIMIT)
    begin
      bready = ($urandom % 3) != 0;  // random stall on B
      @(posedge clk);
      ok = wr_rsp.bvalid && bready;
      @(negedge clk);
      n++;
    end
    bready = 1'b0;
    if (!ok)
    begin
      $display("write response timed out at address 0x%h", addr);
      tb_errors++;
    end
  endtask

  task automatic axil_read(input stream_pkg::addr_t addr, output stream_pkg::word_t data,
                           output logic ok);
    int n;
    data = '0;
    ok = 1'b0;
    rd_req.araddr  = addr;
    rd_req.arvalid = 1'b1;
    n = 0;
    while (!ok && n < HS_LIMIT)
    begin
      @(posedge clk);
      ok = arready;
      @(negedge clk);
      n++;
    end
    rd_req.arvalid = 1'b0;
    if (!ok)
    begin
      $display("read address handshake timed out at address 0x%h", addr);
      tb_errors++;
      return;
    end
    ok = 1'b0;
    n = 0;
    while (!ok && n < HS_LIMIT)
    begin
      rready = ($urandom % 3) != 0;  // random stall on R
      @(posedge clk);
      ok = rd_rsp.rvalid && rready;
      if (ok)
      begin
        data = rd_rsp.rdata;
      end
      @(negedge clk);
      n++;
    end
    rready = 1'b0;
    if (!ok)
    begin
      $display("read response timed out at address 0x%h", addr);
      tb_errors++;
    end
  endtask

  task automatic poll_idle();
    stream_pkg::word_t status;
    logic              ok;
    int                polls;
    status = '0;
    ok = 1'b1;
    polls = 0;
    while (ok && !status[0] && polls < POLL_LIMIT)
    begin
      axil_read(`REG_STATUS, status, ok);
      polls++;
    end
    if (ok && !status[0])
    begin
      $display("accumulator never reported idle after %0d status reads", polls);
      tb_errors++;
    end
  endtask

  initial
  begin
    int                i;
    stream_pkg::word_t rdata;
    logic              ok;
    void'($urandom(3));
    rst_n     = 1'b0;
    wr_req    = '0;
    rd_req    = '0;
    bready    = 1'b0;
    rready    = 1'b0;
    tb_errors = 0;
    load_ops();
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    for (i = 0; i < n_ops; i++)
    begin
      repeat ($urandom % 4) @(negedge clk);
      case (ops[i])
        "W": axil_write(addrs[i], datas[i]);
        "R": axil_read(addrs[i], rdata, ok);
        "P": poll_idle();
        default:
        begin
          $display("unknown operation in golden line %0d", i);
          tb_errors++;
        end
      endcase
    end
    repeat (2) @(negedge clk);
    if (pending != 0)
    begin
      $display("%0d expected responses never arrived", pending);
      tb_errors++;
    end
    $display("checks: %0d, check errors: %0d, other errors: %0d",
             checked, check_errors, tb_errors);
    if (check_errors == 0 && tb_errors == 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
